// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = hf_core_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== files.f ====
+incdir+hdl
hdl/hf_pkg.sv
hdl/hf_lsab_in.sv
hdl/hf_scheduler.sv
hdl/hf_block_mover.sv
hdl/hf_completion.sv
hdl/hf_core.sv
testbench/hf_core_properties.sv
testbench/hf_core_tb.sv

// ==== hdl/hf_block_mover.sv ====
// Section to memory block mover
`timescale 1ns/1ps
`include "hf_config.svh"

module hf_block_mover
  import hf_pkg::*;
(
  input  logic          CLK_n,
  input  logic          RST,
  input  logic          i_cmd_valid,
  input  block_cmd_s    i_cmd,
  input  section_mask_t i_empty,
  input  lsab_word_s    i_head,
  output logic          o_pop,
  output section_t      o_pop_section,
  output logic          o_busy,
  output mem_wr_s       o_mem,
  output logic          o_done,
  output block_done_s   o_done_rec
);

  localparam int OFS_W = `HF_MEM_ADDR_W - `HF_SECTION_W;

  mover_state_e state_q;
  section_t     sec_q;
  mem_addr_t    addr_q;
  count_t       count_q;
  logic         last_q;     // Previous word closed the block
  ancill_t      ancill_q;
  logic         pkt_end_q;
  logic         ending;
  count_t       count_inc;

  assign count_inc = count_q + count_t'(1);

  // Block over once its last word is out or the section ran dry
  assign ending = last_q || i_empty[sec_q];

  assign o_pop         = (state_q == MOVER_MOVE) && !ending;
  assign o_pop_section = sec_q;
  assign o_busy        = o_pop;  // Already low in the done cycle
  assign o_done        = (state_q == MOVER_MOVE) && ending;

  // ------------------------------
  // Write port, one word per pop
  assign o_mem.we   = o_pop;
  assign o_mem.addr = addr_q;
  assign o_mem.data = i_head.data;

  assign o_done_rec.section = sec_q;
  assign o_done_rec.sent    = count_q;
  assign o_done_rec.ancill  = ancill_q;
  assign o_done_rec.pkt_end = pkt_end_q;
  assign o_done_rec.abrupt  = !last_q;

  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      state_q <= MOVER_IDLE;
      count_q <= '0;
      last_q  <= 1'b0;
    end
    else if (state_q == MOVER_IDLE)
    begin
      if (i_cmd_valid)
      begin
        state_q <= MOVER_MOVE;
        count_q <= '0;
        last_q  <= 1'b0;
      end
    end
    else if (ending)
      state_q <= MOVER_IDLE;
    else
    begin
      count_q <= count_inc;
      last_q  <= i_head.pkt_end || (count_inc == count_t'(`HF_BLOCK_LEN));
    end
  end

  // Block payload
  always_ff @(posedge CLK_n)
  begin
    if ((state_q == MOVER_IDLE) && i_cmd_valid)
    begin
      sec_q  <= i_cmd.section;
      addr_q <= i_cmd.start;
    end
    else if (o_pop)
    begin
      addr_q[OFS_W-1:0] <= addr_q[OFS_W-1:0] + OFS_W'(1);  // Stays in region
      ancill_q          <= i_head.ancill;
      pkt_end_q         <= i_head.pkt_end;
    end
  end

endmodule

// ==== hdl/hf_completion.sv ====
// Block completion stage
`timescale 1ns/1ps

module hf_completion
  import hf_pkg::*;
(
  input  logic        CLK_n,
  input  logic        RST,
  input  logic        i_done,
  input  block_done_s i_done_rec,
  output logic        o_done_valid,
  output block_done_s o_done_rec,
  output logic        o_irq
);

  // ------------------------------
  // Done pulse and interrupt level
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      o_done_valid <= 1'b0;
      o_irq        <= 1'b0;
    end
    else
    begin
      o_done_valid <= i_done;
      // Toggle marks a block ending on packet end
      if (i_done && i_done_rec.pkt_end)
        o_irq <= !o_irq;
    end
  end

  // Record held until the next block
  always_ff @(posedge CLK_n)
  begin
    if (i_done)
      o_done_rec <= i_done_rec;
  end

endmodule

// ==== hdl/hf_config.svh ====
// Hyperfabric ingest configuration
`ifndef HF_CONFIG_SVH
`define HF_CONFIG_SVH

// Sections and channels
`define HF_SECTIONS   4
`define HF_SECTION_W  2

// Words held per section
`define HF_FIFO_DEPTH 8

// Data and tag widths
`define HF_WORD_W     32
`define HF_ANCILL_W   3

// Block moves
`define HF_BLOCK_LEN  4
`define HF_MEM_ADDR_W 10  // Top HF_SECTION_W bits select the region

`endif

// ==== hdl/hf_core.sv ====
// Hyperfabric ingest core
`timescale 1ns/1ps

module hf_core
  import hf_pkg::*;
(
  input  logic          CLK_n,
  input  logic          RST,
  input  section_mask_t i_write,
  input  lsab_in_a      i_words,
  output section_t      o_slot,
  output section_mask_t o_full,
  output mem_wr_s       o_mem,
  output logic          o_done_valid,
  output block_done_s   o_done_rec,
  output logic          o_irq
);

  section_mask_t empty;
  logic          pop;
  section_t      pop_section;
  lsab_word_s    head;
  logic          cmd_valid;
  block_cmd_s    cmd;
  logic          busy;
  logic          done;
  block_done_s   done_rec;

  // ------------------------------
  // Input buffer
  hf_lsab_in u_lsab_in (
    .CLK_n         (CLK_n),
    .RST           (RST),
    .i_write       (i_write),
    .i_words       (i_words),
    .i_pop         (pop),
    .i_pop_section (pop_section),
    .o_slot        (o_slot),
    .o_full        (o_full),
    .o_empty       (empty),
    .o_head        (head)
  );

  // Decode
  hf_scheduler u_scheduler (
    .CLK_n       (CLK_n),
    .RST         (RST),
    .i_empty     (empty),
    .i_busy      (busy),
    .i_done      (done),
    .i_done_rec  (done_rec),
    .o_cmd_valid (cmd_valid),
    .o_cmd       (cmd)
  );

  // Execute
  hf_block_mover u_block_mover (
    .CLK_n         (CLK_n),
    .RST           (RST),
    .i_cmd_valid   (cmd_valid),
    .i_cmd         (cmd),
    .i_empty       (empty),
    .i_head        (head),
    .o_pop         (pop),
    .o_pop_section (pop_section),
    .o_busy        (busy),
    .o_mem         (o_mem),
    .o_done        (done),
    .o_done_rec    (done_rec)
  );

  // Result
  hf_completion u_completion (
    .CLK_n        (CLK_n),
    .RST          (RST),
    .i_done       (done),
    .i_done_rec   (done_rec),
    .o_done_valid (o_done_valid),
    .o_done_rec   (o_done_rec),
    .o_irq        (o_irq)
  );

endmodule

// ==== hdl/hf_lsab_in.sv ====
// Input section buffer
`timescale 1ns/1ps
`include "hf_config.svh"

module hf_lsab_in
  import hf_pkg::*;
(
  input  logic          CLK_n,
  input  logic          RST,
  input  section_mask_t i_write,
  input  lsab_in_a      i_words,
  input  logic          i_pop,
  input  section_t      i_pop_section,
  output section_t      o_slot,
  output section_mask_t o_full,
  output section_mask_t o_empty,
  output lsab_word_s    o_head
);

  localparam int PTR_W = $clog2(`HF_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`HF_FIFO_DEPTH + 1);

  lsab_word_s       mem_q [`HF_SECTIONS][`HF_FIFO_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q [`HF_SECTIONS];
  logic [PTR_W-1:0] wr_ptr_q [`HF_SECTIONS];
  logic [CNT_W-1:0] count_q [`HF_SECTIONS];
  section_t         slot_q;
  section_mask_t    accept;
  section_mask_t    pop;

  // Rotating write slot
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
      slot_q <= '0;
    else
      slot_q <= slot_q + section_t'(1);
  end

  always_comb
  begin
    for (int s = 0; s < `HF_SECTIONS; s++)
    begin
      o_full[s]  = (count_q[s] == CNT_W'(`HF_FIFO_DEPTH));
      o_empty[s] = (count_q[s] == '0);
      // Only the channel owning the slot may write
      accept[s]  = i_write[s] && (slot_q == section_t'(s)) && !o_full[s];
      pop[s]     = i_pop && (i_pop_section == section_t'(s)) && !o_empty[s];
    end
  end

  // ------------------------------
  // Section storage
  always_ff @(posedge CLK_n)
  begin
    for (int s = 0; s < `HF_SECTIONS; s++)
    begin
      if (accept[s])
        mem_q[s][wr_ptr_q[s]] <= i_words[s];
    end
  end

  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      for (int s = 0; s < `HF_SECTIONS; s++)
      begin
        rd_ptr_q[s] <= '0;
        wr_ptr_q[s] <= '0;
        count_q[s]  <= '0;
      end
    end
    else
    begin
      for (int s = 0; s < `HF_SECTIONS; s++)
      begin
        if (accept[s])
          wr_ptr_q[s] <= wr_ptr_q[s] + PTR_W'(1);  // Wraps at depth
        if (pop[s])
          rd_ptr_q[s] <= rd_ptr_q[s] + PTR_W'(1);
        if (accept[s] && !pop[s])
          count_q[s] <= count_q[s] + CNT_W'(1);
        else if (pop[s] && !accept[s])
          count_q[s] <= count_q[s] - CNT_W'(1);
      end
    end
  end

  assign o_slot = slot_q;
  assign o_head = mem_q[i_pop_section][rd_ptr_q[i_pop_section]];  // Head of selected section

endmodule

// ==== hdl/hf_pkg.sv ====
// Hyperfabric ingest types
`include "hf_config.svh"

package hf_pkg;

  typedef logic [`HF_WORD_W-1:0]               word_t;
  typedef logic [`HF_ANCILL_W-1:0]             ancill_t;
  typedef logic [`HF_SECTION_W-1:0]            section_t;
  typedef logic [`HF_MEM_ADDR_W-1:0]           mem_addr_t;
  typedef logic [$clog2(`HF_BLOCK_LEN+1)-1:0]  count_t;  // Must reach HF_BLOCK_LEN
  typedef logic [`HF_SECTIONS-1:0]             section_mask_t;

  // ------------------------------
  typedef struct packed {
    word_t   data;
    ancill_t ancill;
    logic    pkt_end;
  } lsab_word_s;

  typedef lsab_word_s [`HF_SECTIONS-1:0] lsab_in_a;  // One word per channel

  typedef struct packed {
    section_t  section;
    mem_addr_t start;
  } block_cmd_s;

  typedef struct packed {
    section_t section;
    count_t   sent;
    ancill_t  ancill;    // Tag of the last word moved
    logic     pkt_end;
    logic     abrupt;    // Section ran dry
  } block_done_s;

  typedef struct packed {
    logic      we;
    mem_addr_t addr;
    word_t     data;
  } mem_wr_s;

  typedef enum logic {SCHED_IDLE, SCHED_BUSY} sched_state_e;
  typedef enum logic {MOVER_IDLE, MOVER_MOVE} mover_state_e;

endpackage

// ==== hdl/hf_scheduler.sv ====
// Block command scheduler
`timescale 1ns/1ps
`include "hf_config.svh"

module hf_scheduler
  import hf_pkg::*;
(
  input  logic          CLK_n,
  input  logic          RST,
  input  section_mask_t i_empty,
  input  logic          i_busy,
  input  logic          i_done,
  input  block_done_s   i_done_rec,
  output logic          o_cmd_valid,
  output block_cmd_s    o_cmd
);

  localparam int OFS_W = `HF_MEM_ADDR_W - `HF_SECTION_W;

  sched_state_e     state_q;
  section_t         last_q;  // Last section served
  logic [OFS_W-1:0] ptr_q [`HF_SECTIONS];
  logic [OFS_W-1:0] ptr_upd [`HF_SECTIONS];
  section_t         pick;
  logic             found;
  logic             issue;

  // Pointers with the finishing block already counted
  always_comb
  begin
    for (int s = 0; s < `HF_SECTIONS; s++)
    begin
      ptr_upd[s] = ptr_q[s];
      if (i_done && (i_done_rec.section == section_t'(s)))
        ptr_upd[s] = ptr_q[s] + OFS_W'(i_done_rec.sent);  // Modulo region size
    end
  end

  // Round-robin search, starting after the last one served
  always_comb
  begin
    section_t cand;
    pick  = last_q;
    found = 1'b0;
    for (int i = 1; i <= `HF_SECTIONS; i++)
    begin
      cand = last_q + section_t'(i);
      if (!found && !i_empty[cand])
      begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  assign issue = ((state_q == SCHED_IDLE) || i_done) && !i_busy && found;

  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      state_q     <= SCHED_IDLE;
      last_q      <= section_t'(`HF_SECTIONS - 1);  // First search begins at 0
      o_cmd_valid <= 1'b0;
      for (int s = 0; s < `HF_SECTIONS; s++)
        ptr_q[s] <= '0;
    end
    else
    begin
      o_cmd_valid <= issue;
      for (int s = 0; s < `HF_SECTIONS; s++)
        ptr_q[s] <= ptr_upd[s];
      if (issue)
      begin
        state_q <= SCHED_BUSY;
        last_q  <= pick;
      end
      else if (i_done)
        state_q <= SCHED_IDLE;
    end
  end

  // Command payload
  always_ff @(posedge CLK_n)
  begin
    if (issue)
    begin
      o_cmd.section <= pick;
      o_cmd.start   <= {pick, ptr_upd[pick]};
    end
  end

endmodule

// ==== testbench/hf_core_properties.sv ====
// Core port assertions
`timescale 1ns/1ps
`include "hf_config.svh"

module hf_core_properties
  import hf_pkg::*;
(
  input logic     CLK_n,
  input logic     RST,
  input logic     i_done_valid,
  input mem_wr_s  i_mem,
  input section_t i_pop_section
);

  // ------------------------------
  a_done_single: assert property (@(posedge CLK_n) disable iff (!RST)
    i_done_valid |=> !i_done_valid)
    else $error("done-valid high for two cycles");

  // Writes land in the region of the section being drained
  a_write_region: assert property (@(posedge CLK_n) disable iff (!RST)
    i_mem.we |-> (i_mem.addr[`HF_MEM_ADDR_W-1 -: `HF_SECTION_W] == i_pop_section))
    else $error("memory write outside the region of section %0d", i_pop_section);

  a_reset_we: assert property (@(posedge CLK_n) !RST |=> !i_mem.we)
    else $error("memory write enable high after reset");

endmodule

bind hf_core hf_core_properties i_hf_core_properties (
  .CLK_n         (CLK_n),
  .RST           (RST),
  .i_done_valid  (o_done_valid),
  .i_mem         (o_mem),
  .i_pop_section (pop_section)
);

// ==== testbench/hf_core_tb.sv ====
// Hyperfabric ingest testbench
`timescale 1ns/1ps
`include "hf_config.svh"

module hf_core_tb
  import hf_pkg::*;
();

  localparam int DEPTH       = `HF_FIFO_DEPTH;
  localparam int OFS_W       = `HF_MEM_ADDR_W - `HF_SECTION_W;
  localparam int FILL_CYCLES = 600;
  localparam int STIM_CYCLES = 5 + 400 + 1200 + 300 + 300 + FILL_CYCLES;
  localparam int CYCLE_LIMIT = 20 * STIM_CYCLES + 200;  // At most one word per cycle

  logic          CLK_n;
  logic          RST;
  section_mask_t wr_strobe;
  lsab_in_a      words;
  section_t      slot;
  section_mask_t full;
  mem_wr_s       mem;
  logic          done_valid;
  block_done_s   done_rec;
  logic          irq;

  // Reference model state
  lsab_word_s       model_q [`HF_SECTIONS][$];  // Accepted but not yet written
  logic [OFS_W-1:0] next_ofs [`HF_SECTIONS];
  int               blk_cnt [`HF_SECTIONS];     // Writes since the last record
  ancill_t          last_ancill [`HF_SECTIONS];
  logic             last_pe [`HF_SECTIONS];
  int               prev_size [`HF_SECTIONS];
  section_t         model_slot;
  logic             model_irq;
  int               accepted;
  int               written;
  int               errors;
  int               tests;
  int               failed_tests;
  int               cycles;

  hf_core i_hf_core (
    .CLK_n        (CLK_n),
    .RST          (RST),
    .i_write      (wr_strobe),
    .i_words      (words),
    .o_slot       (slot),
    .o_full       (full),
    .o_mem        (mem),
    .o_done_valid (done_valid),
    .o_done_rec   (done_rec),
    .o_irq        (irq)
  );

  always #50 CLK_n = !CLK_n;

  // Run limit
  always @(posedge CLK_n)
  begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("mismatch %s: expected %h, got %h", name, exp, act);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("error: %s", msg);
    errors++;
  endtask

  // ------------------------------
  // Check the current outputs and drive the next inputs
  task automatic step(input section_mask_t strobe, input lsab_in_a w);
    int         size_now [`HF_SECTIONS];
    section_t   s;
    lsab_word_s head;
    logic       exp_abrupt;
    for (int i = 0; i < `HF_SECTIONS; i++)
      size_now[i] = model_q[i].size();
    if (slot !== model_slot)
      report_mismatch("o_slot", 32'(model_slot), 32'(slot));
    for (int i = 0; i < `HF_SECTIONS; i++)
    begin
      if (full[i] !== (size_now[i] == DEPTH))
        report_mismatch($sformatf("o_full[%0d]", i), 32'(size_now[i] == DEPTH),
                        32'(full[i]));
    end
    // Record of the block that ended last cycle
    if (done_valid === 1'b1)
    begin
      s          = done_rec.section;
      exp_abrupt = !(last_pe[s] || (blk_cnt[s] == `HF_BLOCK_LEN));
      if ((blk_cnt[s] == 0) || (blk_cnt[s] > `HF_BLOCK_LEN))
        report_error($sformatf("block of section %0d moved %0d words", s, blk_cnt[s]));
      if (done_rec.sent !== count_t'(blk_cnt[s]))
        report_mismatch("o_done_rec.sent", 32'(blk_cnt[s]), 32'(done_rec.sent));
      if (done_rec.ancill !== last_ancill[s])
        report_mismatch("o_done_rec.ancill", 32'(last_ancill[s]), 32'(done_rec.ancill));
      if (done_rec.pkt_end !== last_pe[s])
        report_mismatch("o_done_rec.pkt_end", 32'(last_pe[s]), 32'(done_rec.pkt_end));
      if (done_rec.abrupt !== exp_abrupt)
        report_mismatch("o_done_rec.abrupt", 32'(exp_abrupt), 32'(done_rec.abrupt));
      if (exp_abrupt && (prev_size[s] != 0))
        report_error($sformatf("section %0d stopped early with words waiting", s));
      if (last_pe[s])
        model_irq = !model_irq;
      blk_cnt[s] = 0;
    end
    if (irq !== model_irq)
      report_mismatch("o_irq", 32'(model_irq), 32'(irq));
    if (mem.we === 1'b1)
    begin
      s = mem.addr[`HF_MEM_ADDR_W-1 -: `HF_SECTION_W];
      if (model_q[s].size() == 0)
        report_error($sformatf("memory write to section %0d with no word pending", s));
      else
      begin
        if ((blk_cnt[s] != 0) && last_pe[s])
          report_error($sformatf("section %0d block went on past a packet end", s));
        head = model_q[s].pop_front();
        if (mem.data !== head.data)
          report_mismatch("o_mem.data", head.data, mem.data);
        if (mem.addr !== {s, next_ofs[s]})
          report_mismatch("o_mem.addr", 32'({s, next_ofs[s]}), 32'(mem.addr));
        next_ofs[s]++;  // Wraps inside the region
        blk_cnt[s]++;
        last_ancill[s] = head.ancill;
        last_pe[s]     = head.pkt_end;
        written++;
      end
    end
    else if (mem.we !== 1'b0)
      report_error("memory write enable is unknown");

    wr_strobe = strobe;
    words     = w;
    // Only the in-slot channel with room gets in
    if (RST && strobe[model_slot] && (size_now[model_slot] < DEPTH))
    begin
      model_q[model_slot].push_back(w[model_slot]);
      accepted++;
    end
    for (int i = 0; i < `HF_SECTIONS; i++)
      prev_size[i] = size_now[i];
    model_slot = model_slot + section_t'(1);
    @(negedge CLK_n);
  endtask

  task automatic random_step(input int unsigned strobe_pct, input int unsigned pe_pct);
    section_mask_t strobe;
    lsab_in_a      w;
    for (int i = 0; i < `HF_SECTIONS; i++)
    begin
      strobe[i]    = ($urandom % 100) < strobe_pct;
      w[i].data    = $urandom;
      w[i].ancill  = ancill_t'($urandom);
      w[i].pkt_end = ($urandom % 100) < pe_pct;
    end
    step(strobe, w);
  endtask

  function automatic int pending_words();
    int n;
    n = 0;
    for (int i = 0; i < `HF_SECTIONS; i++)
      n += model_q[i].size() + blk_cnt[i];
    return n;
  endfunction

  // ------------------------------
  task automatic finish_test(input string name, input int errors_before);
    while (pending_words() != 0)
      step('0, '0);
    repeat (4) step('0, '0);  // Idle cycles catch any stray write or record
    for (int i = 0; i < `HF_SECTIONS; i++)
    begin
      if ((model_q[i].size() != 0) || (blk_cnt[i] != 0))
        report_error($sformatf("section %0d not fully drained", i));
    end
    if (accepted != written)
      report_error($sformatf("%0d words accepted but %0d written", accepted, written));
    tests++;
    if (errors == errors_before)
      $display("test %0d %s: ok", tests, name);
    else
    begin
      failed_tests++;
      $display("test %0d %s: failed with %0d errors", tests, name, errors - errors_before);
    end
  endtask

  initial
  begin
    int       start;
    int       rejected;
    section_t target;
    CLK_n     = 1'b0;
    RST       = 1'b0;
    wr_strobe = '0;
    words     = '0;
    for (int i = 0; i < `HF_SECTIONS; i++)
    begin
      next_ofs[i]    = '0;
      blk_cnt[i]     = 0;
      last_ancill[i] = '0;
      last_pe[i]     = 1'b0;
      prev_size[i]   = 0;
    end
    model_slot   = '0;
    model_irq    = 1'b0;
    accepted     = 0;
    written      = 0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    cycles       = 0;
    void'($urandom(32'h46e1));

    repeat (3) @(posedge CLK_n);
    @(negedge CLK_n);
    RST = 1'b1;

    start = errors;
    for (int i = 0; i < 5; i++)
    begin
      if (slot !== section_t'(i % 4))
        report_mismatch("o_slot", 32'(i % 4), 32'(slot));
      if ((mem.we !== 1'b0) || (done_valid !== 1'b0) || (irq !== 1'b0))
        report_error("outputs active right after reset");
      step('0, '0);
    end
    finish_test("reset and slot rotation", start);

    start = errors;
    repeat (400) random_step(50, 12);
    finish_test("slot gating", start);

    start = errors;
    repeat (1200) random_step(90, 6);  // Dense enough to wrap every region
    finish_test("data and address order", start);

    start = errors;
    repeat (300) random_step(12, 25);  // Sparse enough for sections to run dry
    finish_test("block limits", start);

    start = errors;
    repeat (300) random_step(50, 50);
    finish_test("interrupt", start);

    // Writes outrun the mover until the target section fills
    start    = errors;
    target   = section_t'($urandom);
    rejected = 0;
    for (int n = 0; (n < FILL_CYCLES) && (rejected < 8); n++)
    begin
      if ((model_q[target].size() == DEPTH) && (model_slot == target))
        rejected++;
      random_step(100, 0);
    end
    if (rejected == 0)
      report_error($sformatf("section %0d never became full", target));
    finish_test("full sections", start);

    $display("%0d tests, %0d failed, %0d errors, %0d words moved",
             tests, failed_tests, errors, written);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
